// ==== common/jtagPkg.sv ====
// TAP encoding and command codes for the debug port; codes above 0x07 execute as no operation.
package jtagPkg;

    ///////////////////////////////////////////////////////////////////////
    // Register widths.
    ///////////////////////////////////////////////////////////////////////
    localparam int IR_WIDTH = 8;
    localparam int DR_WIDTH = 16;

    // Simplified six-state TAP.
    typedef enum logic [2:0] {
        IDLE   = 3'b000,
        ISEL   = 3'b001,
        DSEL   = 3'b101,
        ISHFT  = 3'b100,
        DSHFT  = 3'b010,
        UPDATE = 3'b110
    } tapState_t;

    // Host pins, already synchronized to clk inside the core.
    typedef struct packed {
        logic tck;
        logic tms;
        logic tdi;
    } jtagPins_t;

    // MCU flags, read out as the low bits of the status word.
    typedef struct packed {
        logic isPaused;
        logic isBooted;
    } mcuStatus_t;

    ///////////////////////////////////////////////////////////////////////
    // Commands held in the instruction register.
    ///////////////////////////////////////////////////////////////////////
    typedef enum logic [IR_WIDTH-1:0] {
        CMD_NOP        = 8'h00,
        CMD_SET_ADDR   = 8'h01,
        CMD_READ_RAM   = 8'h02,
        CMD_WRITE_RAM  = 8'h03,
        CMD_SCAN_RELAY = 8'h04,
        CMD_SPI_RELAY  = 8'h05,
        CMD_RUN        = 8'h06,
        CMD_PAUSE      = 8'h07
    } jtagCmd_t;

    // Update request from the TAP to the executor.
    typedef struct packed {
        jtagCmd_t            command;
        logic [DR_WIDTH-1:0] data;
    } updateReq_t;

endpackage

// ==== common/memPkg.sv ====
// Debug RAM types; addresses are 16 bits wide but the RAM decodes only its low index bits.
package memPkg;

    // Full address width seen by the host.
    localparam int MEM_ADDR_WIDTH = 16;

    typedef logic [MEM_ADDR_WIDTH-1:0] memAddr_t;
    typedef logic [15:0]               memData_t;

    ///////////////////////////////////////////////////////////////////////
    // Request payload, valid while req is high.
    ///////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic     write;
        memAddr_t addr;
        memData_t wdata;
    } memReq_t;

endpackage

// ==== dv/debugSubsystemTb.sv ====
// Host drives pins on falling clk edges at 8 clk per TCK half period; RAM tests stay in word indices 0..15.
`timescale 1ns/100ps

module debugSubsystemTb;

    localparam int CLK_PERIOD  = 4;
    localparam int TCK_HALF    = 8;
    localparam int RAM_DEPTH   = 256;
    localparam int RAM_LATENCY = 3;
    localparam int SETTLE      = 6;

    // Test counts.
    localparam int PRELOAD     = 16;
    localparam int RAM_OPS     = 40;
    localparam int BLOCKED_OPS = 8;
    localparam int RELAY_OPS   = 16;
    localparam int PAUSE_OPS   = 8;
    localparam int WALKS       = 10;
    localparam int WALK_STEPS  = 40;
    localparam int NUM_TESTS   = 1 + PRELOAD + RAM_OPS + BLOCKED_OPS + RELAY_OPS +
                                 PAUSE_OPS + WALKS;

    logic                clk;
    logic                rst;
    jtagPkg::jtagPins_t  jtag;
    jtagPkg::mcuStatus_t mcuStatus;
    logic                jtagTdo;
    logic                enScanRelay;
    logic                enSpiRelay;
    logic                enPaused;

    // MCU model flags.
    logic booted;
    logic pausedFlag = 1'b0;

    logic [15:0] lfsr;
    int          errCount;

    // Reference model of the TAP and executor.
    jtagPkg::tapState_t mState;
    logic [7:0]         mIr;
    logic [15:0]        mDr;
    memPkg::memAddr_t   mAddr;
    memPkg::memData_t   mMem [RAM_DEPTH];
    logic               mScan;
    logic               mSpi;
    logic               mPaused;

    debugSubsystem #(.RAM_DEPTH(RAM_DEPTH), .RAM_LATENCY(RAM_LATENCY)) dut_i (
        .clk(clk), .rst(rst), .jtag(jtag), .mcuStatus(mcuStatus), .jtagTdo(jtagTdo),
        .enScanRelay(enScanRelay), .enSpiRelay(enSpiRelay), .enPaused(enPaused)
    );

    // Paused flag follows the enable.
    always @(negedge clk) begin
        pausedFlag <= enPaused;
    end

    assign mcuStatus.isPaused = pausedFlag;
    assign mcuStatus.isBooted = booted;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog scaled to the test count.
    initial begin
        #(NUM_TESTS * 200 * 2 * TCK_HALF * CLK_PERIOD);
        $display("Watchdog timeout, the run did not finish in time.");
        stopRun();
    end

    ///////////////////////////////////////////////////////////////////////
    // Error handling and compare tasks.
    ///////////////////////////////////////////////////////////////////////
    task automatic stopRun();
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic checkStatus(input jtagPkg::mcuStatus_t got, input jtagPkg::mcuStatus_t exp);
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] t=%0t status got %b expected %b", $time, got, exp);
            stopRun();
        end
    endtask

    task automatic checkData(input string name, input memPkg::memData_t got,
                             input memPkg::memData_t exp);
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkEnable(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkEnables();
        checkEnable("enScanRelay", enScanRelay, mScan);
        checkEnable("enSpiRelay", enSpiRelay, mSpi);
        checkEnable("enPaused", enPaused, mPaused);
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Random numbers, 16-bit Fibonacci LFSR.
    ///////////////////////////////////////////////////////////////////////
    function automatic logic nextBit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], nextBit()};
        end
        return v;
    endfunction

    // Random high bits, index always below 16.
    function automatic memPkg::memAddr_t randAddr();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = randBits(8);
        lo = randBits(4);
        return {hi[7:0], 4'h0, lo[3:0]};
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Reference model, one call per TCK rising edge.
    ///////////////////////////////////////////////////////////////////////
    function automatic void executeUpdate();
        logic inCtl;
        inCtl = mPaused & booted;
        mScan = inCtl && (mIr == jtagPkg::CMD_SCAN_RELAY);
        mSpi  = inCtl && (mIr == jtagPkg::CMD_SPI_RELAY);
        if (mIr == jtagPkg::CMD_SET_ADDR) begin
            mAddr = mDr;
        end
        if ((mIr == jtagPkg::CMD_RUN || mIr == jtagPkg::CMD_PAUSE) && booted) begin
            mPaused = mIr[0];
        end
        if (inCtl && mIr == jtagPkg::CMD_WRITE_RAM) begin
            mMem[mAddr % RAM_DEPTH] = mDr;
        end
        if (inCtl && mIr == jtagPkg::CMD_READ_RAM) begin
            mDr = mMem[mAddr % RAM_DEPTH];
        end
    endfunction

    function automatic void stepModel(input logic tms, input logic tdi);
        jtagPkg::tapState_t next;
        case (mState)
            jtagPkg::IDLE:  next = tms ? jtagPkg::IDLE   : jtagPkg::ISEL;
            jtagPkg::ISEL:  next = tms ? jtagPkg::DSEL   : jtagPkg::ISHFT;
            jtagPkg::DSEL:  next = tms ? jtagPkg::IDLE   : jtagPkg::DSHFT;
            jtagPkg::ISHFT: next = tms ? jtagPkg::UPDATE : jtagPkg::ISHFT;
            jtagPkg::DSHFT: next = tms ? jtagPkg::IDLE   : jtagPkg::DSHFT;
            default:        next = jtagPkg::IDLE;
        endcase
        if (mState == jtagPkg::ISEL && !tms) begin
            mIr = {6'b0, mPaused, booted};
        end else if (mState == jtagPkg::ISHFT) begin
            mIr = {mIr[6:0], tdi};
        end
        if (mState == jtagPkg::DSHFT) begin
            mDr = {mDr[14:0], tdi};
        end
        if (next == jtagPkg::UPDATE) begin
            executeUpdate();
        end
        mState = next;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Host tasks, entered on a falling clk edge.
    ///////////////////////////////////////////////////////////////////////
    task automatic tckStep(input logic tms, input logic tdi, output logic tdo);
        logic expTdo;
        jtag.tck = 1'b0;
        jtag.tms = tms;
        jtag.tdi = tdi;
        repeat (TCK_HALF) @(negedge clk);
        // TDO sampled just before the rising edge.
        expTdo = (mState == jtagPkg::DSHFT) ? mDr[15] : mIr[7];
        tdo    = jtagTdo;
        checkEnable("jtagTdo", tdo, expTdo);
        stepModel(tms, tdi);
        jtag.tck = 1'b1;
        repeat (TCK_HALF) @(negedge clk);
        checkEnables();
    endtask

    // Shift an instruction and execute it, status checked on the way out.
    task automatic shiftIr(input logic [7:0] cmd);
        logic [7:0]          word;
        logic                b;
        jtagPkg::mcuStatus_t expSt;
        expSt.isPaused = mPaused;
        expSt.isBooted = booted;
        word = '0;
        tckStep(1'b0, 1'b0, b);
        tckStep(1'b0, 1'b0, b);
        for (int i = 7; i >= 0; i--) begin
            tckStep(i == 0, cmd[i], b);
            word = {word[6:0], b};
        end
        tckStep(1'b1, 1'b0, b);
        checkStatus(jtagPkg::mcuStatus_t'(word[1:0]), expSt);
        if (word[7:2] !== 6'b0) begin
            errCount++;
            $display("Status word upper bits were not zero: %b", word);
            stopRun();
        end
    endtask

    task automatic shiftDr(input memPkg::memData_t din, output memPkg::memData_t dout);
        logic b;
        dout = '0;
        tckStep(1'b0, 1'b0, b);
        tckStep(1'b1, 1'b0, b);
        tckStep(1'b0, 1'b0, b);
        for (int i = 15; i >= 0; i--) begin
            tckStep(i == 0, din[i], b);
            dout = {dout[14:0], b};
        end
    endtask

    task automatic writeWord(input memPkg::memAddr_t addr, input memPkg::memData_t data);
        memPkg::memData_t old;
        shiftDr(addr, old);
        shiftIr(jtagPkg::CMD_SET_ADDR);
        shiftDr(data, old);
        shiftIr(jtagPkg::CMD_WRITE_RAM);
    endtask

    // Trailing shift leaves a safe address in the data register.
    task automatic readWord(input memPkg::memAddr_t addr, output memPkg::memData_t got);
        memPkg::memData_t old;
        shiftDr(addr, old);
        shiftIr(jtagPkg::CMD_SET_ADDR);
        shiftIr(jtagPkg::CMD_READ_RAM);
        shiftDr(randAddr(), got);
    endtask

    task automatic setBooted(input logic b);
        booted = b;
        repeat (SETTLE) @(negedge clk);
    endtask

    task automatic takeControl();
        setBooted(1'b1);
        shiftIr(jtagPkg::CMD_PAUSE);
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Test sequence.
    ///////////////////////////////////////////////////////////////////////
    initial begin
        memPkg::memAddr_t addr;
        memPkg::memData_t data;
        memPkg::memData_t got;
        logic             tms;
        logic             tdi;
        logic             b;
        rst      = 1'b1;
        jtag     = '0;
        booted   = 1'b0;
        lfsr     = 16'd64187;
        errCount = 0;
        mState   = jtagPkg::IDLE;
        mIr      = '0;
        mDr      = '0;
        mAddr    = '0;
        mScan    = 1'b0;
        mSpi     = 1'b0;
        mPaused  = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (SETTLE) @(negedge clk);

        // Reset values and first status word, pause refused while not booted.
        checkEnables();
        shiftIr(jtagPkg::CMD_PAUSE);

        // Fill the test window under control.
        takeControl();
        for (int i = 0; i < PRELOAD; i++) begin
            addr = randAddr();
            addr[3:0] = i[3:0];
            writeWord(addr, randBits(16));
        end

        for (int i = 0; i < RAM_OPS; i++) begin
            addr = randAddr();
            if (nextBit()) begin
                writeWord(addr, randBits(16));
            end else begin
                readWord(addr, got);
                checkData("ramRead", got, mMem[addr % RAM_DEPTH]);
            end
        end

        // Out of control. Blocked read leaves the shifted address in place.
        for (int i = 0; i < BLOCKED_OPS; i++) begin
            addr = randAddr();
            data = randBits(16);
            if (nextBit()) begin
                shiftIr(jtagPkg::CMD_RUN);
            end else begin
                setBooted(1'b0);
            end
            writeWord(addr, data);
            readWord(addr, got);
            checkData("blockedRead", got, addr);
            takeControl();
            readWord(addr, got);
            checkData("ramRead", got, mMem[addr % RAM_DEPTH]);
        end

        // Relays, codes above 0x07 included.
        for (int i = 0; i < RELAY_OPS; i++) begin
            data = randBits(4);
            if (!i[0]) begin
                // Scan or SPI relay raised under control.
                takeControl();
                data[3:1] = 3'b010;
            end else begin
                // Control dropped while a relay is still enabled.
                setBooted(1'b0);
                if (i[1]) begin
                    data[3:1] = 3'b010;
                end
            end
            shiftDr(randAddr(), got);
            shiftIr(data[7:0]);
            checkEnables();
        end

        // Run and pause, status read back by a NOP.
        for (int i = 0; i < PAUSE_OPS; i++) begin
            setBooted(nextBit());
            shiftIr(nextBit() ? jtagPkg::CMD_PAUSE : jtagPkg::CMD_RUN);
            shiftIr(jtagPkg::CMD_NOP);
        end

        // Random TMS walks.
        setBooted(1'b0);
        for (int w = 0; w < WALKS; w++) begin
            for (int s = 0; s < WALK_STEPS; s++) begin
                tms = nextBit();
                tdi = nextBit();
                tckStep(tms, tdi, b);
            end
        end
        while (mState != jtagPkg::IDLE) begin
            tckStep(1'b1, 1'b0, b);
        end

        if (errCount == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("Errors were counted during the run.");
            stopRun();
        end
    end

endmodule

// ==== files.f ====
common/jtagPkg.sv
common/memPkg.sv
hdl/pinSync.sv
jtagPort/jtagTap.sv
jtagPort/debugExecutor.sv
hdl/debugRam.sv
hdl/debugSubsystem.sv
dv/debugSubsystemTb.sv

// ==== hdl/debugRam.sv ====
// Single-port RAM; ack rises RAM_LATENCY cycles after req is first seen, contents come up undefined.
`timescale 1ns/100ps

module debugRam #(
    parameter int RAM_DEPTH   = 256,
    parameter int RAM_LATENCY = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            req,
    input  memPkg::memReq_t memReq,
    output logic            ack,
    output memPkg::memData_t rdata
);

    localparam int IDX_W = $clog2(RAM_DEPTH);
    localparam int CNT_W = (RAM_LATENCY > 1) ? $clog2(RAM_LATENCY) : 1;

    memPkg::memData_t mem [RAM_DEPTH];

    logic [CNT_W-1:0] cnt;
    logic [IDX_W-1:0] idx;
    logic             fire;

    // Low address bits only.
    assign idx  = memReq.addr[IDX_W-1:0];
    assign fire = req && !ack && (cnt == CNT_W'(RAM_LATENCY - 1));

    ///////////////////////////////////////////////////////////////////////
    // Latency counter and four-phase ack.
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
            ack <= 1'b0;
        end else if (fire) begin
            cnt <= '0;
            ack <= 1'b1;
        end else if (req && !ack) begin
            cnt <= cnt + 1'b1;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    // Access happens on the ack edge.
    always_ff @(posedge clk) begin
        if (fire) begin
            if (memReq.write) begin
                mem[idx] <= memReq.wdata;
            end
            rdata <= mem[idx];
        end
    end

endmodule

// ==== hdl/debugSubsystem.sv ====
// Debug port top; host must hold TCK at least 8 clk per half period, RAM_LATENCY limited to 1..4.
`timescale 1ns/100ps

module debugSubsystem #(
    parameter int RAM_DEPTH   = 256,
    parameter int RAM_LATENCY = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  jtagPkg::jtagPins_t  jtag,
    input  jtagPkg::mcuStatus_t mcuStatus,
    output logic                jtagTdo,
    output logic                enScanRelay,
    output logic                enSpiRelay,
    output logic                enPaused
);

    jtagPkg::jtagPins_t  syncedPins;
    jtagPkg::mcuStatus_t syncedStatus;

    // TAP to executor.
    logic                updReq;
    jtagPkg::updateReq_t updData;
    logic                updAck;
    memPkg::memData_t    updRdata;
    logic                updRdataValid;

    // Executor to RAM.
    logic             memReqValid;
    memPkg::memReq_t  memReq;
    logic             memAck;
    memPkg::memData_t memRdata;

    ///////////////////////////////////////////////////////////////////////
    // Synchronizers.
    ///////////////////////////////////////////////////////////////////////
    pinSync #(.T(jtagPkg::jtagPins_t)) syncPins_i (
        .clk(clk), .rst(rst), .d(jtag), .q(syncedPins)
    );

    pinSync #(.T(jtagPkg::mcuStatus_t)) syncStatus_i (
        .clk(clk), .rst(rst), .d(mcuStatus), .q(syncedStatus)
    );

    jtagTap jtagTap_i (
        .clk(clk), .rst(rst), .pins(syncedPins), .status(syncedStatus), .tdo(jtagTdo),
        .updReq(updReq), .updData(updData), .updAck(updAck), .updRdata(updRdata),
        .updRdataValid(updRdataValid)
    );

    debugExecutor debugExecutor_i (
        .clk(clk), .rst(rst), .status(syncedStatus),
        .updReq(updReq), .updData(updData), .updAck(updAck),
        .updRdata(updRdata), .updRdataValid(updRdataValid),
        .memReqValid(memReqValid), .memReq(memReq), .memAck(memAck), .memRdata(memRdata),
        .enScanRelay(enScanRelay), .enSpiRelay(enSpiRelay), .enPaused(enPaused)
    );

    debugRam #(.RAM_DEPTH(RAM_DEPTH), .RAM_LATENCY(RAM_LATENCY)) debugRam_i (
        .clk(clk), .rst(rst), .req(memReqValid), .memReq(memReq),
        .ack(memAck), .rdata(memRdata)
    );

endmodule

// ==== hdl/pinSync.sv ====
// Two-flop synchronizer for any packed type; bits are synchronized independently, no bus coherency.
`timescale 1ns/100ps

module pinSync #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  T     d,
    output T     q
);

    // First stage, may go metastable.
    T meta;

    always_ff @(posedge clk) begin
        if (rst) begin
            meta <= '0;
            q    <= '0;
        end else begin
            meta <= d;
            q    <= meta;
        end
    end

endmodule

// ==== jtagPort/debugExecutor.sv ====
// Executes one command per update; RAM and relay commands need the MCU both paused and booted.
`timescale 1ns/100ps

module debugExecutor (
    input  logic                clk,
    input  logic                rst,
    input  jtagPkg::mcuStatus_t status,
    input  logic                updReq,
    input  jtagPkg::updateReq_t updData,
    output logic                updAck,
    output memPkg::memData_t    updRdata,
    output logic                updRdataValid,
    output logic                memReqValid,
    output memPkg::memReq_t     memReq,
    input  logic                memAck,
    input  memPkg::memData_t    memRdata,
    output logic                enScanRelay,
    output logic                enSpiRelay,
    output logic                enPaused
);

    // Executor sequencing.
    typedef enum logic [1:0] {
        EX_IDLE,
        EX_MEM,
        EX_ACK
    } exState_t;

    exState_t         exState;
    memPkg::memAddr_t addrReg;
    logic             inControl;
    logic             isMemCmd;

    assign inControl = status.isPaused & status.isBooted;
    assign isMemCmd  = (updData.command == jtagPkg::CMD_READ_RAM) ||
                       (updData.command == jtagPkg::CMD_WRITE_RAM);

    ///////////////////////////////////////////////////////////////////////
    // Command decode and handshakes.
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            exState       <= EX_IDLE;
            addrReg       <= '0;
            updAck        <= 1'b0;
            updRdataValid <= 1'b0;
            memReqValid   <= 1'b0;
            enScanRelay   <= 1'b0;
            enSpiRelay    <= 1'b0;
            enPaused      <= 1'b0;
        end else begin
            case (exState)
                EX_IDLE: begin
                    if (updReq) begin
                        // Relays rewritten on every command.
                        enScanRelay <= inControl &&
                                       (updData.command == jtagPkg::CMD_SCAN_RELAY);
                        enSpiRelay  <= inControl &&
                                       (updData.command == jtagPkg::CMD_SPI_RELAY);
                        if (updData.command == jtagPkg::CMD_SET_ADDR) begin
                            addrReg <= updData.data;
                        end
                        // Run and pause differ only in bit 0.
                        if ((updData.command == jtagPkg::CMD_RUN ||
                             updData.command == jtagPkg::CMD_PAUSE) && status.isBooted) begin
                            enPaused <= updData.command[0];
                        end
                        if (isMemCmd && inControl) begin
                            memReqValid <= 1'b1;
                            exState     <= EX_MEM;
                        end else begin
                            // Register-only, blocked or NOP.
                            updAck  <= 1'b1;
                            exState <= EX_ACK;
                        end
                    end
                end
                EX_MEM: begin
                    if (memAck) begin
                        memReqValid   <= 1'b0;
                        updAck        <= 1'b1;
                        updRdataValid <= ~memReq.write;
                        exState       <= EX_ACK;
                    end
                end
                default: begin
                    // Wait for both requests to drop.
                    if (!updReq && !memAck) begin
                        updAck        <= 1'b0;
                        updRdataValid <= 1'b0;
                        exState       <= EX_IDLE;
                    end
                end
            endcase
        end
    end

    // Payload registers.
    always_ff @(posedge clk) begin
        if (exState == EX_IDLE && updReq) begin
            memReq.write <= (updData.command == jtagPkg::CMD_WRITE_RAM);
            memReq.addr  <= addrReg;
            memReq.wdata <= updData.data;
        end
        if (exState == EX_MEM && memAck) begin
            updRdata <= memRdata;
        end
    end

endmodule

// ==== jtagPort/jtagTap.sv ====
// TAP in the clk domain; TCK half period must exceed the executor handshake, edges during it are dropped.
`timescale 1ns/100ps

module jtagTap (
    input  logic                clk,
    input  logic                rst,
    input  jtagPkg::jtagPins_t  pins,
    input  jtagPkg::mcuStatus_t status,
    output logic                tdo,
    output logic                updReq,
    output jtagPkg::updateReq_t updData,
    input  logic                updAck,
    input  memPkg::memData_t    updRdata,
    input  logic                updRdataValid
);

    jtagPkg::tapState_t state;
    jtagPkg::tapState_t stateNext;

    logic [jtagPkg::IR_WIDTH-1:0] iReg;
    logic [jtagPkg::DR_WIDTH-1:0] dReg;

    // TCK edge detection.
    logic tckPrev;
    logic busy;
    logic tckEdge;

    // Handshake in flight, TCK edges are ignored.
    assign busy    = updReq | updAck;
    assign tckEdge = pins.tck & ~tckPrev & ~busy;

    ///////////////////////////////////////////////////////////////////////
    // Next state by TMS.
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        case (state)
            jtagPkg::IDLE:   stateNext = pins.tms ? jtagPkg::IDLE   : jtagPkg::ISEL;
            jtagPkg::ISEL:   stateNext = pins.tms ? jtagPkg::DSEL   : jtagPkg::ISHFT;
            jtagPkg::DSEL:   stateNext = pins.tms ? jtagPkg::IDLE   : jtagPkg::DSHFT;
            jtagPkg::ISHFT:  stateNext = pins.tms ? jtagPkg::UPDATE : jtagPkg::ISHFT;
            jtagPkg::DSHFT:  stateNext = pins.tms ? jtagPkg::IDLE   : jtagPkg::DSHFT;
            jtagPkg::UPDATE: stateNext = jtagPkg::IDLE;
            default:         stateNext = jtagPkg::IDLE;
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // State, shift registers and update handshake.
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            tckPrev <= 1'b0;
            state   <= jtagPkg::IDLE;
            iReg    <= '0;
            dReg    <= '0;
            updReq  <= 1'b0;
        end else begin
            tckPrev <= pins.tck;
            if (tckEdge) begin
                state <= stateNext;
                // Status capture on entry to the instruction shift.
                if (state == jtagPkg::ISEL && !pins.tms) begin
                    iReg <= {{(jtagPkg::IR_WIDTH-2){1'b0}}, status.isPaused, status.isBooted};
                end else if (state == jtagPkg::ISHFT) begin
                    // Exiting edge shifts too.
                    iReg <= {iReg[jtagPkg::IR_WIDTH-2:0], pins.tdi};
                end
                if (state == jtagPkg::DSHFT) begin
                    dReg <= {dReg[jtagPkg::DR_WIDTH-2:0], pins.tdi};
                end
                // Launch on entry to UPDATE.
                if (stateNext == jtagPkg::UPDATE) begin
                    updReq <= 1'b1;
                end
            end else if (updReq && updAck) begin
                updReq <= 1'b0;
                // Read data lands only if the executor allowed it.
                if (updData.command == jtagPkg::CMD_READ_RAM && updRdataValid) begin
                    dReg <= updRdata;
                end
            end
        end
    end

    // Registers are frozen while updReq is high, so the payload is stable.
    assign updData.command = jtagPkg::jtagCmd_t'(iReg);
    assign updData.data    = dReg;

    // Data MSB only while shifting data.
    assign tdo = (state == jtagPkg::DSHFT) ? dReg[jtagPkg::DR_WIDTH-1]
                                           : iReg[jtagPkg::IR_WIDTH-1];

endmodule
